// File: verilog/sysmon_params.svh
`ifndef SYSMON_PARAMS_SVH
`define SYSMON_PARAMS_SVH

// host byte counter width
`define BYTECNT_SIZE 7

// host register map
`define XADC_DRP_ADDR 8'd52   // drp address, bit 7 = write
`define XADC_DRP_DATA 8'd53   // drp data window, byte per bytecnt
`define XADC_STAT     8'd54   // alarm status

// conversion result registers
`define ADDR_TEMP         7'h00
`define ADDR_VCCINT       7'h01
`define ADDR_VCCAUX       7'h02
`define ADDR_VBRAM        7'h06

// alarm threshold registers
`define ADDR_TEMP_UPPER   7'h50
`define ADDR_VCCINT_UPPER 7'h51
`define ADDR_VCCAUX_UPPER 7'h52
`define ADDR_OT_UPPER     7'h53
`define ADDR_TEMP_RESET   7'h54
`define ADDR_VCCINT_LOWER 7'h55
`define ADDR_VCCAUX_LOWER 7'h56
`define ADDR_OT_RESET     7'h57
`define ADDR_VBRAM_UPPER  7'h58
`define ADDR_VBRAM_LOWER  7'h5C

`define UPPER_RESET_VAL 16'hFFFF  // upper and ot thresholds
`define LOWER_RESET_VAL 16'h0000  // lower and temp reset thresholds

`endif

// File: verilog/host_reg_pkg.sv
`default_nettype none

// host byte bus side
package host_reg_pkg;

  typedef logic [7:0] reg_addr_t;  // host register address
  typedef logic [7:0] reg_byte_t;  // one data byte on the host bus

endpackage

`default_nettype wire

// File: verilog/sysmon_drp_pkg.sv
`default_nettype none

// drp and monitor side
package sysmon_drp_pkg;

  typedef logic [6:0]  drp_addr_t;   // drp register address
  typedef logic [15:0] drp_word_t;   // conversion result or threshold
  typedef logic [4:0]  alarm_vec_t;  // one bit per alarm

  // bit positions in alarm_vec_t in the same order as the status register
  typedef enum logic [2:0] {
    OT        = 3'd0,  // over-temperature
    USER_TEMP = 3'd1,  // user temperature alarm
    VCCINT    = 3'd2,
    VCCAUX    = 3'd3,
    VBRAM     = 3'd4
  } alarm_idx_e;

endpackage

`default_nettype wire

// File: verilog/xadc_reg_bridge.sv
`default_nettype none
`timescale 1ns/10ps
`include "sysmon_params.svh"

// a drp write loads the data window bytes and then the address with bit 7 set
// a drp read writes the address with bit 7 clear and then reads the data window
module xadc_reg_bridge (
  input  wire                             clk_usb,
  input  wire                             reset_i,
  input  wire host_reg_pkg::reg_addr_t    reg_address,  // host register select
  input  wire [`BYTECNT_SIZE-1:0]         reg_bytecnt,  // byte within the word
  input  wire host_reg_pkg::reg_byte_t    reg_datai,    // write byte
  output host_reg_pkg::reg_byte_t         reg_datao,    // read byte, one clock late
  input  wire                             reg_read,     // level
  input  wire                             reg_write,    // one-cycle strobe
  output logic                            xadc_error,   // any alarm
  output sysmon_drp_pkg::drp_addr_t       drp_addr,
  output sysmon_drp_pkg::drp_word_t       drp_din,
  output logic                            drp_den,
  output logic                            drp_dwe,
  input  wire sysmon_drp_pkg::drp_word_t  drp_dout,
  input  wire                             drp_drdy,
  input  wire sysmon_drp_pkg::alarm_vec_t alarms
);
  import host_reg_pkg::*;
  import sysmon_drp_pkg::*;

  drp_word_t hold_word;  // last drp read result
  logic      rd_cycle;   // pending drdy belongs to a read
  logic      byte_ok;    // bytecnt is 0 or 1
  logic      addr_wr;    // host writes the drp address
  reg_byte_t rd_byte;    // read mux output

  assign addr_wr = reg_write && (reg_address == `XADC_DRP_ADDR);
  assign byte_ok = (reg_bytecnt[`BYTECNT_SIZE-1:1] == '0);  // upper bytes don't exist

  assign xadc_error = |alarms;

  // address write launches a drp cycle next clock
  always_ff @(posedge clk_usb) begin
    if (reset_i) begin
      drp_den  <= 1'b0;
      drp_dwe  <= 1'b0;
      drp_addr <= '0;
    end else if (addr_wr) begin
      drp_den  <= 1'b1;
      drp_dwe  <= reg_datai[7];    // msb picks write
      drp_addr <= reg_datai[6:0];
    end else begin
      drp_den  <= 1'b0;  // single pulse
      drp_dwe  <= 1'b0;
    end
  end

  // pending write word built a byte at a time
  always_ff @(posedge clk_usb) begin
    if (reg_write && (reg_address == `XADC_DRP_DATA) && byte_ok) begin
      if (reg_bytecnt[0])
        drp_din[15:8] <= reg_datai;  // high byte
      else
        drp_din[7:0]  <= reg_datai;  // low byte
    end
  end

  always_ff @(posedge clk_usb) begin
    if (reset_i)
      rd_cycle <= 1'b0;
    else
      rd_cycle <= drp_den && !drp_dwe;  // drdy arrives one clock after den
  end

  always_ff @(posedge clk_usb) begin
    if (drp_drdy && rd_cycle)
      hold_word <= drp_dout;  // write cycles leave it alone
  end

  always_comb begin
    case (reg_address)
      `XADC_DRP_ADDR: rd_byte = {1'b0, drp_addr};  // direction bit not kept
      `XADC_DRP_DATA: begin
        if (!byte_ok)
          rd_byte = '0;
        else if (reg_bytecnt[0])
          rd_byte = hold_word[15:8];
        else
          rd_byte = hold_word[7:0];
      end
      `XADC_STAT:     rd_byte = {3'b000, alarms};
      default:        rd_byte = '0;  // unknown register
    endcase
  end

  always_ff @(posedge clk_usb) begin
    if (reset_i)
      reg_datao <= '0;
    else if (reg_read)
      reg_datao <= rd_byte;
    else
      reg_datao <= '0;  // bus idles at zero
  end

endmodule

`default_nettype wire

// File: verilog/sysmon_core.sv
`default_nettype none
`timescale 1ns/10ps
`include "sysmon_params.svh"

module sysmon_core (
  input  wire                            clk_usb,
  input  wire                            reset_i,
  input  wire sysmon_drp_pkg::drp_addr_t drp_addr,
  input  wire sysmon_drp_pkg::drp_word_t drp_din,
  input  wire                            drp_den,
  input  wire                            drp_dwe,
  output sysmon_drp_pkg::drp_word_t      drp_dout,      // zero outside drdy
  output logic                           drp_drdy,
  input  wire                            sample_valid,  // one-cycle strobe
  input  wire sysmon_drp_pkg::drp_addr_t sample_channel,
  input  wire sysmon_drp_pkg::drp_word_t sample_value,
  output sysmon_drp_pkg::drp_word_t      temp_val,
  output sysmon_drp_pkg::drp_word_t      vccint_val,
  output sysmon_drp_pkg::drp_word_t      vccaux_val,
  output sysmon_drp_pkg::drp_word_t      vbram_val,
  output sysmon_drp_pkg::drp_word_t      temp_upper,
  output sysmon_drp_pkg::drp_word_t      temp_reset,
  output sysmon_drp_pkg::drp_word_t      ot_upper,
  output sysmon_drp_pkg::drp_word_t      ot_reset,
  output sysmon_drp_pkg::drp_word_t      vccint_upper,
  output sysmon_drp_pkg::drp_word_t      vccint_lower,
  output sysmon_drp_pkg::drp_word_t      vccaux_upper,
  output sysmon_drp_pkg::drp_word_t      vccaux_lower,
  output sysmon_drp_pkg::drp_word_t      vbram_upper,
  output sysmon_drp_pkg::drp_word_t      vbram_lower
);
  import sysmon_drp_pkg::*;

  drp_word_t rd_word;  // addressed register

  always_comb begin
    case (drp_addr)
      `ADDR_TEMP:         rd_word = temp_val;
      `ADDR_VCCINT:       rd_word = vccint_val;
      `ADDR_VCCAUX:       rd_word = vccaux_val;
      `ADDR_VBRAM:        rd_word = vbram_val;
      `ADDR_TEMP_UPPER:   rd_word = temp_upper;
      `ADDR_VCCINT_UPPER: rd_word = vccint_upper;
      `ADDR_VCCAUX_UPPER: rd_word = vccaux_upper;
      `ADDR_OT_UPPER:     rd_word = ot_upper;
      `ADDR_TEMP_RESET:   rd_word = temp_reset;
      `ADDR_VCCINT_LOWER: rd_word = vccint_lower;
      `ADDR_VCCAUX_LOWER: rd_word = vccaux_lower;
      `ADDR_OT_RESET:     rd_word = ot_reset;
      `ADDR_VBRAM_UPPER:  rd_word = vbram_upper;
      `ADDR_VBRAM_LOWER:  rd_word = vbram_lower;
      default:            rd_word = '0;  // unmapped
    endcase
  end

  // every den gets a drdy one clock later
  always_ff @(posedge clk_usb) begin
    if (reset_i) begin
      drp_drdy <= 1'b0;
      drp_dout <= '0;
    end else begin
      drp_drdy <= drp_den;
      drp_dout <= drp_den ? rd_word : '0;  // value before any write this cycle
    end
  end

  // thresholds, drp writes only
  always_ff @(posedge clk_usb) begin
    if (reset_i) begin
      temp_upper   <= `UPPER_RESET_VAL;
      vccint_upper <= `UPPER_RESET_VAL;
      vccaux_upper <= `UPPER_RESET_VAL;
      vbram_upper  <= `UPPER_RESET_VAL;
      ot_upper     <= `UPPER_RESET_VAL;
      ot_reset     <= `UPPER_RESET_VAL;
      temp_reset   <= `LOWER_RESET_VAL;
      vccint_lower <= `LOWER_RESET_VAL;
      vccaux_lower <= `LOWER_RESET_VAL;
      vbram_lower  <= `LOWER_RESET_VAL;
    end else if (drp_den && drp_dwe) begin
      case (drp_addr)
        `ADDR_TEMP_UPPER:   temp_upper   <= drp_din;
        `ADDR_VCCINT_UPPER: vccint_upper <= drp_din;
        `ADDR_VCCAUX_UPPER: vccaux_upper <= drp_din;
        `ADDR_OT_UPPER:     ot_upper     <= drp_din;
        `ADDR_TEMP_RESET:   temp_reset   <= drp_din;
        `ADDR_VCCINT_LOWER: vccint_lower <= drp_din;
        `ADDR_VCCAUX_LOWER: vccaux_lower <= drp_din;
        `ADDR_OT_RESET:     ot_reset     <= drp_din;
        `ADDR_VBRAM_UPPER:  vbram_upper  <= drp_din;
        `ADDR_VBRAM_LOWER:  vbram_lower  <= drp_din;
        default: ;  // conversions are read-only on drp
      endcase
    end
  end

  // conversion results, sample strobe only
  always_ff @(posedge clk_usb) begin
    if (reset_i) begin
      temp_val   <= '0;
      vccint_val <= '0;
      vccaux_val <= '0;
      vbram_val  <= '0;
    end else if (sample_valid) begin
      case (sample_channel)
        `ADDR_TEMP:   temp_val   <= sample_value;
        `ADDR_VCCINT: vccint_val <= sample_value;
        `ADDR_VCCAUX: vccaux_val <= sample_value;
        `ADDR_VBRAM:  vbram_val  <= sample_value;
        default: ;  // other channels dropped
      endcase
    end
  end

endmodule

`default_nettype wire

// File: verilog/alarm_monitor.sv
`default_nettype none
`timescale 1ns/10ps

module alarm_monitor (
  input  wire                             clk_usb,
  input  wire                             reset_i,
  input  wire sysmon_drp_pkg::drp_word_t  temp_val,
  input  wire sysmon_drp_pkg::drp_word_t  vccint_val,
  input  wire sysmon_drp_pkg::drp_word_t  vccaux_val,
  input  wire sysmon_drp_pkg::drp_word_t  vbram_val,
  input  wire sysmon_drp_pkg::drp_word_t  temp_upper,
  input  wire sysmon_drp_pkg::drp_word_t  temp_reset,
  input  wire sysmon_drp_pkg::drp_word_t  ot_upper,
  input  wire sysmon_drp_pkg::drp_word_t  ot_reset,
  input  wire sysmon_drp_pkg::drp_word_t  vccint_upper,
  input  wire sysmon_drp_pkg::drp_word_t  vccint_lower,
  input  wire sysmon_drp_pkg::drp_word_t  vccaux_upper,
  input  wire sysmon_drp_pkg::drp_word_t  vccaux_lower,
  input  wire sysmon_drp_pkg::drp_word_t  vbram_upper,
  input  wire sysmon_drp_pkg::drp_word_t  vbram_lower,
  output sysmon_drp_pkg::alarm_vec_t      alarms  // registered
);
  import sysmon_drp_pkg::*;

  // temperature alarm with hysteresis where set wins if the thresholds cross
  function automatic logic hyst_next(input logic cur, input drp_word_t val,
                                     input drp_word_t hi, input drp_word_t lo);
    logic nxt;
    nxt = cur;           // between thresholds, hold
    if (val >= hi)
      nxt = 1'b1;
    else if (val < lo)
      nxt = 1'b0;
    return nxt;
  endfunction

  // supply outside its window
  function automatic logic out_of_window(input drp_word_t val, input drp_word_t hi,
                                         input drp_word_t lo);
    return (val > hi) || (val < lo);
  endfunction

  always_ff @(posedge clk_usb) begin
    if (reset_i) begin
      alarms <= '0;
    end else begin
      alarms[OT]        <= hyst_next(alarms[OT], temp_val, ot_upper, ot_reset);
      alarms[USER_TEMP] <= hyst_next(alarms[USER_TEMP], temp_val, temp_upper, temp_reset);
      alarms[VCCINT]    <= out_of_window(vccint_val, vccint_upper, vccint_lower);
      alarms[VCCAUX]    <= out_of_window(vccaux_val, vccaux_upper, vccaux_lower);
      alarms[VBRAM]     <= out_of_window(vbram_val, vbram_upper, vbram_lower);
    end
  end

endmodule

`default_nettype wire

// File: verilog/xadc_subsystem.sv
`default_nettype none
`timescale 1ns/10ps
`include "sysmon_params.svh"

module xadc_subsystem (
  input  wire                             clk_usb,
  input  wire                             reset_i,
  input  wire host_reg_pkg::reg_addr_t    reg_address,
  input  wire [`BYTECNT_SIZE-1:0]         reg_bytecnt,
  input  wire host_reg_pkg::reg_byte_t    reg_datai,
  output host_reg_pkg::reg_byte_t         reg_datao,
  input  wire                             reg_read,
  input  wire                             reg_write,
  output wire                             xadc_error,
  input  wire                             sample_valid,   // conversion done
  input  wire sysmon_drp_pkg::drp_addr_t  sample_channel,
  input  wire sysmon_drp_pkg::drp_word_t  sample_value
);
  import sysmon_drp_pkg::*;

  drp_addr_t  drp_addr;
  drp_word_t  drp_din, drp_dout;
  logic       drp_den, drp_dwe, drp_drdy;
  alarm_vec_t alarms;

  drp_word_t temp_val, vccint_val, vccaux_val, vbram_val;       // conversions
  drp_word_t temp_upper, temp_reset, ot_upper, ot_reset;       // temp thresholds
  drp_word_t vccint_upper, vccint_lower, vccaux_upper, vccaux_lower;
  drp_word_t vbram_upper, vbram_lower;

  xadc_reg_bridge i_xadc_reg_bridge (
    .clk_usb, .reset_i, .reg_address, .reg_bytecnt, .reg_datai, .reg_datao,
    .reg_read, .reg_write, .xadc_error,
    .drp_addr, .drp_din, .drp_den, .drp_dwe, .drp_dout, .drp_drdy,
    .alarms
  );

  sysmon_core i_sysmon_core (
    .clk_usb, .reset_i,
    .drp_addr, .drp_din, .drp_den, .drp_dwe, .drp_dout, .drp_drdy,
    .sample_valid, .sample_channel, .sample_value,
    .temp_val, .vccint_val, .vccaux_val, .vbram_val,
    .temp_upper, .temp_reset, .ot_upper, .ot_reset,
    .vccint_upper, .vccint_lower, .vccaux_upper, .vccaux_lower,
    .vbram_upper, .vbram_lower
  );

  alarm_monitor i_alarm_monitor (
    .clk_usb, .reset_i,
    .temp_val, .vccint_val, .vccaux_val, .vbram_val,
    .temp_upper, .temp_reset, .ot_upper, .ot_reset,
    .vccint_upper, .vccint_lower, .vccaux_upper, .vccaux_lower,
    .vbram_upper, .vbram_lower,
    .alarms
  );

endmodule

`default_nettype wire

// File: verification/xadc_properties.sv
`default_nettype none
`timescale 1ns/10ps
`include "sysmon_params.svh"

// drp strobe rules and the error flag inside xadc_reg_bridge
module xadc_properties (
  input wire                          clk_usb,
  input wire                          reset_i,
  input wire host_reg_pkg::reg_addr_t reg_address,
  input wire                          reg_read,
  input wire host_reg_pkg::reg_byte_t reg_datao,
  input wire                          drp_den,
  input wire                          drp_dwe,
  input wire                          drp_drdy,
  input wire                          xadc_error
);

  int fail_count = 0;  // summed into the testbench totals

  den_single: assert property (@(posedge clk_usb) disable iff (reset_i)
    drp_den |=> !drp_den)
    else begin
      $error("drp_den high on two clocks in a row");
      fail_count++;
    end

  dwe_with_den: assert property (@(posedge clk_usb) disable iff (reset_i)
    drp_dwe |-> drp_den)
    else begin
      $error("drp_dwe high without drp_den");
      fail_count++;
    end

  // drdy exactly one clock behind den and never on its own
  drdy_follows_den: assert property (@(posedge clk_usb) disable iff (reset_i)
    drp_drdy == $past(drp_den))
    else begin
      $error("drp_drdy not one clock after drp_den");
      fail_count++;
    end

  // a status read shows an alarm bit exactly when the error flag was up
  error_matches_stat: assert property (@(posedge clk_usb) disable iff (reset_i)
    (reg_read && reg_address == `XADC_STAT) |=> ((|reg_datao) == $past(xadc_error)))
    else begin
      $error("status byte disagrees with xadc_error");
      fail_count++;
    end

endmodule

`default_nettype wire

// File: verification/xadc_tb.sv
`default_nettype none
`timescale 1ns/10ps
`include "sysmon_params.svh"

module xadc_tb;
  import host_reg_pkg::*;
  import sysmon_drp_pkg::*;

  localparam int N_SAMPLES = 24;  // test 3 iterations
  localparam int N_ALARM   = 40;  // test 4 iterations
  localparam int N_IDLE    = 8;   // test 5 iterations
  localparam int NUM_OPS   = 60 + 2 * (N_SAMPLES + N_ALARM + N_IDLE);  // host operations
  localparam int TIMEOUT_CYCLES = NUM_OPS * 20 + 1000;

  logic                     clk_usb = 1'b0;
  logic                     reset_i;
  reg_addr_t                reg_address;
  logic [`BYTECNT_SIZE-1:0] reg_bytecnt;
  reg_byte_t                reg_datai;
  reg_byte_t                reg_datao;
  logic                     reg_read;
  logic                     reg_write;
  logic                     xadc_error;
  logic                     sample_valid;
  drp_addr_t                sample_channel;
  drp_word_t                sample_value;

  logic [15:0] lfsr = 16'd75;      // stimulus seed
  drp_word_t   model_regs [0:127];  // expected drp register contents
  alarm_vec_t  model_alarms;        // expected alarm states
  int          checks = 0;
  int          errors = 0;
  int          test_errors = 0;     // error count at the start of the current test

  xadc_subsystem i_xadc_subsystem (
    .clk_usb(clk_usb), .reset_i(reset_i), .reg_address(reg_address),
    .reg_bytecnt(reg_bytecnt), .reg_datai(reg_datai), .reg_datao(reg_datao),
    .reg_read(reg_read), .reg_write(reg_write), .xadc_error(xadc_error),
    .sample_valid(sample_valid), .sample_channel(sample_channel),
    .sample_value(sample_value)
  );

  bind xadc_reg_bridge xadc_properties i_xadc_properties (
    .clk_usb(clk_usb), .reset_i(reset_i), .reg_address(reg_address),
    .reg_read(reg_read), .reg_datao(reg_datao), .drp_den(drp_den),
    .drp_dwe(drp_dwe), .drp_drdy(drp_drdy), .xadc_error(xadc_error)
  );

  always #5 clk_usb = ~clk_usb;  // 10 ns period

  // fibonacci lfsr with taps 16 14 13 11 and one step per bit taken
  function automatic logic [15:0] rand_bits(input int n);
    logic [15:0] r;
    logic        fb;
    int          i;
    r = '0;
    for (i = 0; i < n; i++) begin
      fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
      lfsr = {lfsr[14:0], fb};
      r = {r[14:0], fb};
    end
    return r;
  endfunction

  function automatic drp_addr_t threshold_addr(input int idx);
    case (idx)
      0: return `ADDR_TEMP_UPPER;
      1: return `ADDR_VCCINT_UPPER;
      2: return `ADDR_VCCAUX_UPPER;
      3: return `ADDR_OT_UPPER;
      4: return `ADDR_TEMP_RESET;
      5: return `ADDR_VCCINT_LOWER;
      6: return `ADDR_VCCAUX_LOWER;
      7: return `ADDR_OT_RESET;
      8: return `ADDR_VBRAM_UPPER;
      default: return `ADDR_VBRAM_LOWER;
    endcase
  endfunction

  function automatic drp_addr_t conversion_addr(input int idx);
    case (idx)
      0: return `ADDR_TEMP;
      1: return `ADDR_VCCINT;
      2: return `ADDR_VCCAUX;
      default: return `ADDR_VBRAM;
    endcase
  endfunction

  function automatic logic is_threshold(input drp_addr_t a);
    return (a >= `ADDR_TEMP_UPPER && a <= `ADDR_VBRAM_UPPER) || a == `ADDR_VBRAM_LOWER;
  endfunction

  function automatic logic is_conversion(input drp_addr_t a);
    return a <= `ADDR_VCCAUX || a == `ADDR_VBRAM;
  endfunction

  task automatic reset_model();
    model_regs = '{default: 16'h0000};  // conversions and lower thresholds
    model_regs[`ADDR_TEMP_UPPER]   = `UPPER_RESET_VAL;
    model_regs[`ADDR_VCCINT_UPPER] = `UPPER_RESET_VAL;
    model_regs[`ADDR_VCCAUX_UPPER] = `UPPER_RESET_VAL;
    model_regs[`ADDR_VBRAM_UPPER]  = `UPPER_RESET_VAL;
    model_regs[`ADDR_OT_UPPER]     = `UPPER_RESET_VAL;
    model_regs[`ADDR_OT_RESET]     = `UPPER_RESET_VAL;
    model_alarms = '0;
  endtask

  // evaluated once per value change and set wins when the thresholds cross
  task automatic update_alarm_model();
    drp_word_t t;
    t = model_regs[`ADDR_TEMP];
    if (t >= model_regs[`ADDR_OT_UPPER])
      model_alarms[OT] = 1'b1;
    else if (t < model_regs[`ADDR_OT_RESET])
      model_alarms[OT] = 1'b0;
    if (t >= model_regs[`ADDR_TEMP_UPPER])
      model_alarms[USER_TEMP] = 1'b1;
    else if (t < model_regs[`ADDR_TEMP_RESET])
      model_alarms[USER_TEMP] = 1'b0;
    model_alarms[VCCINT] = model_regs[`ADDR_VCCINT] > model_regs[`ADDR_VCCINT_UPPER] ||
                           model_regs[`ADDR_VCCINT] < model_regs[`ADDR_VCCINT_LOWER];
    model_alarms[VCCAUX] = model_regs[`ADDR_VCCAUX] > model_regs[`ADDR_VCCAUX_UPPER] ||
                           model_regs[`ADDR_VCCAUX] < model_regs[`ADDR_VCCAUX_LOWER];
    model_alarms[VBRAM]  = model_regs[`ADDR_VBRAM] > model_regs[`ADDR_VBRAM_UPPER] ||
                           model_regs[`ADDR_VBRAM] < model_regs[`ADDR_VBRAM_LOWER];
  endtask

  task automatic model_write(input drp_addr_t a, input drp_word_t w);
    if (is_threshold(a))
      model_regs[a] = w;  // conversions ignore drp writes
    update_alarm_model();
  endtask

  task automatic model_sample(input drp_addr_t a, input drp_word_t w);
    if (is_conversion(a))
      model_regs[a] = w;
    update_alarm_model();
  endtask

  task automatic check(input string name, input logic [15:0] expected,
                       input logic [15:0] actual);
    checks++;
    if (expected !== actual) begin
      errors++;
      $display("ERR %0t %s expected %h got %h", $time, name, expected, actual);
    end
  endtask

  task automatic end_test(input int num, input string desc);
    $display("test %0d %s done, %0d errors", num, desc, errors - test_errors);
    test_errors = errors;
  endtask

  // one write strobe that returns on the next falling edge
  task automatic host_write(input reg_addr_t addr, input logic hi, input reg_byte_t data);
    reg_address = addr;
    reg_bytecnt = '0;
    reg_bytecnt[0] = hi;
    reg_datai = data;
    reg_write = 1'b1;
    @(negedge clk_usb);
    reg_write = 1'b0;
  endtask

  // read level held for one clock with the byte registered at the rising edge between
  task automatic host_read(input reg_addr_t addr, input logic hi, output reg_byte_t data);
    reg_address = addr;
    reg_bytecnt = '0;
    reg_bytecnt[0] = hi;
    reg_read = 1'b1;
    @(negedge clk_usb);
    data = reg_datao;
    reg_read = 1'b0;
  endtask

  task automatic drp_write(input drp_addr_t a, input drp_word_t w);
    host_write(`XADC_DRP_DATA, 1'b0, w[7:0]);
    host_write(`XADC_DRP_DATA, 1'b1, w[15:8]);
    host_write(`XADC_DRP_ADDR, 1'b0, {1'b1, a});  // bit 7 launches a write
    repeat (2) @(negedge clk_usb);  // register and then alarms
  endtask

  task automatic drp_read(input drp_addr_t a, output drp_word_t w);
    reg_byte_t lo;
    reg_byte_t hi;
    host_write(`XADC_DRP_ADDR, 1'b0, {1'b0, a});
    repeat (2) @(negedge clk_usb);  // den, drdy, hold word
    host_read(`XADC_DRP_DATA, 1'b0, lo);
    host_read(`XADC_DRP_DATA, 1'b1, hi);
    w = {hi, lo};
  endtask

  task automatic apply_sample(input drp_addr_t chan, input drp_word_t val);
    sample_channel = chan;
    sample_value = val;
    sample_valid = 1'b1;
    @(negedge clk_usb);
    sample_valid = 1'b0;
    @(negedge clk_usb);  // alarms one clock after the store
  endtask

  initial begin : watchdog
    repeat (TIMEOUT_CYCLES) @(posedge clk_usb);
    $display("timeout: tests still running after %0d clocks", TIMEOUT_CYCLES);
    $display("Done: errors found");
    $finish;
  end

  initial begin : main
    drp_word_t w;
    drp_word_t got;
    drp_addr_t a;
    reg_addr_t ha;
    reg_byte_t b;
    int        i;
    int        afails;
    reset_i = 1'b1;
    reg_address = '0;
    reg_bytecnt = '0;
    reg_datai = '0;
    reg_read = 1'b0;
    reg_write = 1'b0;
    sample_valid = 1'b0;
    sample_channel = '0;
    sample_value = '0;
    reset_model();
    repeat (8) @(negedge clk_usb);
    reset_i = 1'b0;

    host_read(`XADC_STAT, 1'b0, b);
    check("xadc_stat", 16'h0000, {8'h00, b});
    check("xadc_error", 16'h0000, {15'd0, xadc_error});
    for (i = 0; i < 14; i++) begin
      a = (i < 10) ? threshold_addr(i) : conversion_addr(i - 10);
      drp_read(a, got);
      check("drp_data", model_regs[a], got);
    end
    end_test(1, "reset values");

    for (i = 0; i < 10; i++) begin
      a = threshold_addr(i);
      w = rand_bits(16);
      drp_write(a, w);
      model_write(a, w);
      host_read(`XADC_DRP_ADDR, 1'b0, b);
      check("drp_addr", {9'd0, a}, {8'h00, b});  // write bit not kept
      drp_read(a, got);
      check("drp_data", model_regs[a], got);
    end
    for (i = 0; i < 4; i++) begin
      a = conversion_addr(i);
      drp_write(a, rand_bits(16));
      drp_read(a, got);
      check("drp_data", model_regs[a], got);  // still the reset value
    end
    end_test(2, "threshold writes");

    for (i = 0; i < N_SAMPLES; i++) begin
      if (rand_bits(1) == 16'd1)
        a = conversion_addr(int'(rand_bits(2)));
      else
        a = drp_addr_t'(rand_bits(7));  // mostly unmapped channels
      w = rand_bits(16);
      apply_sample(a, w);
      model_sample(a, w);
      drp_read(a, got);
      check("drp_data", model_regs[a], got);
    end
    drp_read(7'h03, got);
    check("drp_data", 16'h0000, got);
    drp_read(7'h7F, got);
    check("drp_data", 16'h0000, got);
    end_test(3, "samples");

    for (i = 0; i < N_ALARM; i++) begin
      if (rand_bits(2) == 16'd0) begin
        a = threshold_addr(int'(rand_bits(4)) % 10);
        w = rand_bits(4) << 12;  // coarse grid makes equal values common
        drp_write(a, w);
        model_write(a, w);
      end else begin
        a = conversion_addr(int'(rand_bits(2)));
        w = rand_bits(4) << 12;
        apply_sample(a, w);
        model_sample(a, w);
      end
      host_read(`XADC_STAT, 1'b0, b);
      check("xadc_stat", {11'd0, model_alarms}, {8'h00, b});
      check("xadc_error", {15'd0, |model_alarms}, {15'd0, xadc_error});
    end
    end_test(4, "alarms");

    apply_sample(`ADDR_VCCINT, 16'h1234);
    model_sample(`ADDR_VCCINT, 16'h1234);
    drp_write(`ADDR_VCCINT_LOWER, 16'h2000);  // forces a vccint alarm
    model_write(`ADDR_VCCINT_LOWER, 16'h2000);
    host_read(`XADC_STAT, 1'b0, b);
    check("xadc_stat", {11'd0, model_alarms}, {8'h00, b});
    for (i = 0; i < N_IDLE; i++) begin
      ha = reg_addr_t'(rand_bits(8));
      if (ha >= `XADC_DRP_ADDR && ha <= `XADC_STAT)
        ha = ha + 8'd3;  // step past the map
      host_read(ha, 1'b0, b);
      check("reg_datao", 16'h0000, {8'h00, b});
      reg_address = `XADC_STAT;  // nonzero byte while read is low
      @(negedge clk_usb);
      check("reg_datao", 16'h0000, {8'h00, reg_datao});
    end
    end_test(5, "idle bus");

    afails = i_xadc_subsystem.i_xadc_reg_bridge.i_xadc_properties.fail_count;
    $display("%0d checks, %0d errors, %0d assertion failures", checks, errors, afails);
    if (errors == 0 && afails == 0)
      $display("Done: no errors");
    else
      $display("Done: errors found");
    $finish;
  end

endmodule

`default_nettype wire

// File: xadc_subsystem.f
+incdir+verilog
verilog/host_reg_pkg.sv
verilog/sysmon_drp_pkg.sv
verilog/xadc_reg_bridge.sv
verilog/sysmon_core.sv
verilog/alarm_monitor.sv
verilog/xadc_subsystem.sv
verification/xadc_properties.sv
verification/xadc_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/10ps -j 0
TOP       = xadc_tb
FILELIST  = xadc_subsystem.f
SIM_ARGS  = +verilator+error+limit+1000
LOG       = sim.log
FAIL_MSG  = Done: errors found
BIN       = obj_dir/V$(TOP)

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	$(BIN) $(SIM_ARGS) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi

clean:
	rm -rf obj_dir $(LOG)
